// File: design/pix_cfg_pkg.sv
/* Pixel matrix configuration */
package pix_cfg_pkg;

    parameter int MAX_ROWS   = 16;                  // Row arbiter limit
    parameter int MAX_COLS   = 16;                  // Column arbiter limit
    parameter int MAX_PIXELS = 32;                  // One mask bit per pixel

    typedef logic [3:0] row_addr_t;                 // Row index
    typedef logic [3:0] col_addr_t;                 // Column index
    typedef logic [5:0] fifo_cnt_t;                 // FIFO fill level

    typedef enum logic [1:0]
    {
        ARB_IDLE = 2'b00,                           // Nothing pending
        ARB_ROW  = 2'b01,                           // Pick next row
        ARB_COL  = 2'b10                            // Drain picked row
    } arb_state_t;

endpackage

// File: design/pix_apb_pkg.sv
/* APB register map */
package pix_apb_pkg;

    typedef logic [3:0]  apb_addr_t;                // Byte address
    typedef logic [31:0] apb_data_t;                // Bus word

    parameter apb_addr_t REG_CTRL   = 4'h0;         // Enable
    parameter apb_addr_t REG_MASK   = 4'h4;         // Pixel mask, 1 blocks
    parameter apb_addr_t REG_STATUS = 4'h8;         // FIFO flags and level
    parameter apb_addr_t REG_DATA   = 4'hC;         // FIFO head, read pops

    parameter int CTRL_EN_BIT      = 0;             // Readout enable
    parameter int STATUS_EMPTY_BIT = 8;
    parameter int STATUS_FULL_BIT  = 9;             // Level sits in 5:0
    parameter int DATA_VALID_BIT   = 31;            // Entry present
    parameter int DATA_ROW_LSB     = 4;             // Row in 7:4
    parameter int DATA_COL_LSB     = 0;             // Column in 3:0

endpackage

// File: design/pix_addr_if.sv
/* Pixel address handshake */
`timescale 1ns/100ps

interface pix_addr_if
    import pix_cfg_pkg::*;
();

    logic      valid;                               // Address offered
    logic      ready;                               // Sink has room
    row_addr_t row;                                 // Pixel row
    col_addr_t col;                                 // Pixel column

    modport src
    (
        output valid, row, col,
        input  ready
    );

    modport dst
    (
        input  valid, row, col,
        output ready
    );

endinterface

// File: design/hit_capture.sv
/* Hit latch */
`timescale 1ns/100ps

module hit_capture
#(
    parameter int ROWS = 4,
    parameter int COLS = 4
)
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,          // Latching on
    input  logic [ROWS*COLS-1:0] mask_i,            // 1 blocks the pixel
    input  logic [ROWS*COLS-1:0] hit_i,             // One-cycle pulses
    input  logic [ROWS*COLS-1:0] clr_i,             // Transferred pixel, one-hot
    output logic [ROWS*COLS-1:0] pending_o          // Awaiting readout
);

    localparam int PIX = ROWS * COLS;

    logic [PIX-1:0] hit_new;                        // Hits past mask and enable

    assign hit_new = enable_i ? (hit_i & ~mask_i) : '0;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            pending_o <= '0;
        else
            pending_o <= (pending_o & ~clr_i) | hit_new;    // Fresh hit beats clear
    end

    // Arbiter may only clear a pixel it saw pending
    a_clr_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        (clr_i & ~pending_o) == '0)
        else $error("hit_capture: clear on a pixel that is not pending");

endmodule

// File: design/rr_arbiter.sv
/* Round-robin arbiter */
`timescale 1ns/100ps

module rr_arbiter
#(
    parameter  int N  = 4,
    localparam int IW = (N > 1) ? $clog2(N) : 1
)
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic [N-1:0]  req_i,                    // Requesters
    input  logic          advance_i,                // Grant consumed
    output logic [N-1:0]  gnt_o,                    // One-hot winner
    output logic [IW-1:0] idx_o                     // Winner index
);

    logic [IW-1:0] ptr_q;                           // Highest priority slot
    logic          found;                           // Winner placed

    // First requester at or after the pointer
    always_comb
    begin
        int k;                                      // Candidate slot
        gnt_o = '0;
        idx_o = '0;
        found = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            k = int'(ptr_q) + i;
            if (k >= N)
                k = k - N;                          // Wrap
            if (!found && req_i[k])
            begin
                found    = 1'b1;
                gnt_o[k] = 1'b1;
                idx_o    = IW'(k);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ptr_q <= '0;
        else if (advance_i && found)
            ptr_q <= (idx_o == IW'(N - 1)) ? '0 : idx_o + 1'b1;    // Just past winner
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o))
        else $error("rr_arbiter: more than one grant");

endmodule

// File: design/matrix_arbiter.sv
/* Row then column arbitration */
`timescale 1ns/100ps

module matrix_arbiter
    import pix_cfg_pkg::*;
#(
    parameter int ROWS = 4,
    parameter int COLS = 4
)
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [ROWS*COLS-1:0] pending_i,         // Pending flags, row-major
    output logic [ROWS*COLS-1:0] clr_o,             // Pixel taken this cycle
    pix_addr_if.src              addr               // Toward address FIFO
);

    localparam int PIX = ROWS * COLS;
    localparam int RW  = (ROWS > 1) ? $clog2(ROWS) : 1;
    localparam int CW  = (COLS > 1) ? $clog2(COLS) : 1;

    arb_state_t      state_q, state_d;
    logic [ROWS-1:0] row_or;                        // Row holds a pending pixel
    logic [ROWS-1:0] row_req, row_gnt;
    logic [ROWS-1:0] row_gnt_q;                     // Row under drain
    logic [RW-1:0]   row_idx;
    logic            row_adv;
    logic [COLS-1:0] col_pend;                      // Flags of selected row
    logic [COLS-1:0] col_req, col_gnt;
    logic [COLS-1:0] col_hold_q;                    // Offer left waiting
    logic [CW-1:0]   col_idx;
    logic            stall_q;                       // Last offer refused
    logic            xfer;

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
            row_or[r] = |pending_i[r*COLS +: COLS];
    end

    assign row_req  = (state_q == ARB_COL) ? row_gnt_q : row_or;   // Pin row while draining
    assign col_pend = pending_i[row_idx*COLS +: COLS];
    assign col_req  = stall_q ? col_hold_q : col_pend;              // Freeze waiting offer
    assign row_adv  = (state_q == ARB_COL) && (col_pend == '0);     // Row emptied

    assign addr.valid = (state_q == ARB_COL) && (col_gnt != '0);
    assign addr.row   = row_addr_t'(row_idx);
    assign addr.col   = col_addr_t'(col_idx);
    assign xfer       = addr.valid && addr.ready;
    assign clr_o      = xfer ? (PIX'(1) << (row_idx * COLS + col_idx)) : '0;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE:
                if (pending_i != '0)
                    state_d = ARB_ROW;
            ARB_ROW:
                state_d = (row_or != '0) ? ARB_COL : ARB_IDLE;
            ARB_COL:
                if (col_pend == '0)
                    state_d = ARB_ROW;                  // Next row
            default:
                state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q   <= ARB_IDLE;
            stall_q   <= 1'b0;
            row_gnt_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            stall_q <= addr.valid && !addr.ready;
            if (state_q == ARB_ROW)
                row_gnt_q <= row_gnt;                   // Latch picked row
        end
    end

    always_ff @(posedge clk_i)
    begin
        col_hold_q <= col_gnt;
    end

    rr_arbiter #(.N(ROWS)) u_row_arb
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (row_req),
        .advance_i (row_adv),
        .gnt_o     (row_gnt),
        .idx_o     (row_idx)
    );

    rr_arbiter #(.N(COLS)) u_col_arb
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (col_req),
        .advance_i (xfer),                          // One step per transfer
        .gnt_o     (col_gnt),
        .idx_o     (col_idx)
    );

    // Offer holds until the FIFO takes it
    a_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        addr.valid && !addr.ready |=> addr.valid && $stable(addr.row) && $stable(addr.col))
        else $error("matrix_arbiter: offer changed under back-pressure");

endmodule

// File: design/addr_fifo.sv
/* Pixel address FIFO */
`timescale 1ns/100ps

module addr_fifo
    import pix_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic      clk_i,
    input  logic      reset_i,
    pix_addr_if.dst   wr,                           // From arbiter
    input  logic      pop_i,                        // Head consumed
    output row_addr_t rd_row_o,                     // Head row
    output col_addr_t rd_col_o,                     // Head column
    output logic      empty_o,
    output logic      full_o,
    output fifo_cnt_t count_o                       // Entries held
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    row_addr_t     row_mem [FIFO_DEPTH];
    col_addr_t     col_mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr_q, rd_ptr_q;
    logic          push, pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;     // Wrap at depth
    endfunction

    assign wr.ready = !full_o;
    assign push     = wr.valid && wr.ready;
    assign pop      = pop_i && !empty_o;
    assign empty_o  = (count_o == '0);
    assign full_o   = (count_o == fifo_cnt_t'(FIFO_DEPTH));
    assign rd_row_o = row_mem[rd_ptr_q];            // Show-ahead head
    assign rd_col_o = col_mem[rd_ptr_q];

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_o  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_o <= count_o + fifo_cnt_t'(1);
                2'b01:   count_o <= count_o - fifo_cnt_t'(1);
                default: count_o <= count_o;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
        begin
            row_mem[wr_ptr_q] <= wr.row;
            col_mem[wr_ptr_q] <= wr.col;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o)
        else $error("addr_fifo: pop while empty");

    a_no_overfill: assert property (@(posedge clk_i) disable iff (reset_i)
        count_o <= fifo_cnt_t'(FIFO_DEPTH))
        else $error("addr_fifo: level beyond depth");

endmodule

// File: design/apb_readout_regs.sv
/* APB readout registers */
`timescale 1ns/100ps

module apb_readout_regs
    import pix_cfg_pkg::*;
    import pix_apb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_addr_t             paddr_i,
    input  apb_data_t             pwdata_i,
    output apb_data_t             prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  enable_o,         // CTRL enable
    output logic [MAX_PIXELS-1:0] mask_o,           // 1 blocks the pixel
    output logic                  pop_o,            // FIFO head read out
    input  row_addr_t             fifo_row_i,
    input  col_addr_t             fifo_col_i,
    input  logic                  fifo_empty_i,
    input  logic                  fifo_full_i,
    input  fifo_cnt_t             fifo_count_i,
    output logic                  irq_o             // Data waiting
);

    logic      access;                              // APB access phase
    logic      addr_ok;                             // Mapped register
    apb_data_t rdata;

    assign access    = psel_i && penable_i;
    assign addr_ok   = paddr_i inside {REG_CTRL, REG_MASK, REG_STATUS, REG_DATA};
    assign pready_o  = 1'b1;                        // No wait states
    assign pslverr_o = access && !addr_ok;
    assign pop_o     = access && !pwrite_i && (paddr_i == REG_DATA) && !fifo_empty_i;
    assign prdata_o  = (access && !pwrite_i) ? rdata : '0;

    always_comb
    begin
        rdata = '0;
        case (paddr_i)
            REG_CTRL:
                rdata[CTRL_EN_BIT] = enable_o;
            REG_MASK:
                rdata = apb_data_t'(mask_o);
            REG_STATUS:
            begin
                rdata[$bits(fifo_cnt_t)-1:0] = fifo_count_i;   // Level in low bits
                rdata[STATUS_EMPTY_BIT]      = fifo_empty_i;
                rdata[STATUS_FULL_BIT]       = fifo_full_i;
            end
            REG_DATA:
            begin
                if (!fifo_empty_i)                  // Empty reads as zero
                begin
                    rdata[DATA_VALID_BIT]                    = 1'b1;
                    rdata[DATA_ROW_LSB +: $bits(row_addr_t)] = fifo_row_i;
                    rdata[DATA_COL_LSB +: $bits(col_addr_t)] = fifo_col_i;
                end
            end
            default:
                rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            enable_o <= 1'b0;
            mask_o   <= '0;
            irq_o    <= 1'b0;
        end
        else
        begin
            irq_o <= enable_o && !fifo_empty_i;
            if (access && pwrite_i)
            begin
                case (paddr_i)
                    REG_CTRL: enable_o <= pwdata_i[CTRL_EN_BIT];
                    REG_MASK: mask_o   <= pwdata_i[MAX_PIXELS-1:0];
                    default:  enable_o <= enable_o;     // Read-only or unmapped
                endcase
            end
        end
    end

endmodule

// File: design/pix_readout_top.sv
/* Pixel readout top */
`timescale 1ns/100ps

module pix_readout_top
    import pix_cfg_pkg::*;
    import pix_apb_pkg::*;
#(
    parameter int ROWS       = 4,
    parameter int COLS       = 4,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [ROWS*COLS-1:0] hit_i,             // Pixel hit pulses
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  apb_addr_t            paddr_i,
    input  apb_data_t            pwdata_i,
    output apb_data_t            prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output logic                 irq_o              // FIFO holds data
);

    localparam int PIX = ROWS * COLS;

    logic [PIX-1:0]        pending;                 // Capture to arbiter
    logic [PIX-1:0]        clr;                     // Arbiter to capture
    logic                  enable;
    logic [MAX_PIXELS-1:0] mask;
    logic                  pop;
    row_addr_t             fifo_row;
    col_addr_t             fifo_col;
    logic                  fifo_empty, fifo_full;
    fifo_cnt_t             fifo_count;

    pix_addr_if addr_bus ();                        // Arbiter to FIFO

    initial
    begin
        assert (ROWS >= 1 && ROWS <= MAX_ROWS && COLS >= 1 && COLS <= MAX_COLS &&
                PIX <= MAX_PIXELS && FIFO_DEPTH >= 1 &&
                FIFO_DEPTH < 2 ** $bits(fifo_cnt_t))
        else $fatal(1, "pix_readout_top: matrix or FIFO size out of range");
    end

    hit_capture #(.ROWS(ROWS), .COLS(COLS)) u_capture
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (enable),
        .mask_i    (mask[PIX-1:0]),                 // Upper mask bits unused
        .hit_i     (hit_i),
        .clr_i     (clr),
        .pending_o (pending)
    );

    matrix_arbiter #(.ROWS(ROWS), .COLS(COLS)) u_arbiter
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .pending_i (pending),
        .clr_o     (clr),
        .addr      (addr_bus.src)
    );

    addr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wr       (addr_bus.dst),
        .pop_i    (pop),
        .rd_row_o (fifo_row),
        .rd_col_o (fifo_col),
        .empty_o  (fifo_empty),
        .full_o   (fifo_full),
        .count_o  (fifo_count)
    );

    apb_readout_regs u_regs
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .enable_o     (enable),
        .mask_o       (mask),
        .pop_o        (pop),
        .fifo_row_i   (fifo_row),
        .fifo_col_i   (fifo_col),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_count_i (fifo_count),
        .irq_o        (irq_o)
    );

endmodule

// File: dv/pix_apb_tasks.svh
/* APB host tasks */
`ifndef PIX_APB_TASKS_SVH
`define PIX_APB_TASKS_SVH

localparam int APB_WAIT_LIMIT = 16;                 // Cycles allowed for pready

// One transfer: setup phase, access phase, then bus back to idle
task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                        output apb_data_t rdata, output logic err);
    int waits;
    @(negedge clk_i);
    psel_i    = 1'b1;                               // Setup phase
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;                               // Access phase
    waits     = 0;
    #1;
    while (pready_o !== 1'b1)
    begin
        if (waits >= APB_WAIT_LIMIT)
            abort_run($sformatf("APB access to address %h never got pready", addr));
        else
        begin
            waits++;
            @(negedge clk_i);
            #1;
        end
    end
    rdata = prdata_o;                               // Mid access phase, before the pop edge
    err   = pslverr_o;
    @(posedge clk_i);
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
endtask

task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    logic      err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_flag("pslverr_o", 1'b0, err);             // Mapped register
endtask

task automatic reg_read(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_flag("pslverr_o", 1'b0, err);
endtask

`endif

// File: dv/pix_readout_tb.sv
/* Pixel readout testbench */
`timescale 1ns/100ps

module pix_readout_tb
    import pix_cfg_pkg::*;
    import pix_apb_pkg::*;
();

    localparam int ROWS         = 4;
    localparam int COLS         = 4;
    localparam int FIFO_DEPTH   = 8;
    localparam int PIX          = ROWS * COLS;
    localparam int RANDOM_STEPS = 400;              // Hit cycles in random test
    localparam int DRAIN_LIMIT  = 200;              // DATA reads before giving up
    localparam int POLL_LIMIT   = 50;               // STATUS polls before giving up
    localparam logic [PIX-1:0] FIRST_BATCH = PIX'((1 << FIFO_DEPTH) - 1);   // Fills FIFO

    logic           clk_i;
    logic           reset_i;
    logic [PIX-1:0] hit_i;
    logic           psel_i;
    logic           penable_i;
    logic           pwrite_i;
    apb_addr_t      paddr_i;
    apb_data_t      pwdata_i;
    apb_data_t      prdata_o;
    logic           pready_o;
    logic           pslverr_o;
    logic           irq_o;

    logic [PIX-1:0] outstanding;                    // Model: hit, not yet read out
    logic [PIX-1:0] mask_model;                     // Model copy of MASK
    logic           enabled;                        // Model copy of CTRL enable
    string          test_name;

    pix_readout_top #(.ROWS(ROWS), .COLS(COLS), .FIFO_DEPTH(FIFO_DEPTH)) dut0
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .hit_i     (hit_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .irq_o     (irq_o)
    );

    always #4 clk_i = ~clk_i;                       // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_addr(input row_addr_t exp_row, input col_addr_t exp_col,
                              input row_addr_t got_row, input col_addr_t got_col);
        if (exp_row !== got_row || exp_col !== got_col)
            abort_run($sformatf("Error: %s: expected row %0d col %0d, actual row %0d col %0d",
                                test_name, exp_row, exp_col, got_row, got_col));
    endtask

    task automatic check_data(input apb_data_t exp, input apb_data_t got);
        if (exp !== got)
            abort_run($sformatf("Error: %s: expected %h, actual %h", test_name, exp, got));
    endtask

    task automatic check_count(input fifo_cnt_t exp, input fifo_cnt_t got);
        if (exp !== got)
            abort_run($sformatf("Error: %s: expected level %0d, actual %0d",
                                test_name, exp, got));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (exp !== got)
            abort_run($sformatf("Error: %s: %s expected %b, actual %b",
                                test_name, what, exp, got));
    endtask

    `include "pix_apb_tasks.svh"

    // STATUS as the register map defines it
    function automatic apb_data_t status_word(input fifo_cnt_t cnt);
        apb_data_t w;
        w                   = apb_data_t'(cnt);     // Level in 5:0
        w[STATUS_EMPTY_BIT] = (cnt == 0);
        w[STATUS_FULL_BIT]  = (cnt == FIFO_DEPTH);
        return w;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // One-cycle hit pulse, latched by the model like the capture stage
    task automatic pulse_hits(input logic [PIX-1:0] vec);
        @(negedge clk_i);
        hit_i = vec;
        if (enabled)
            outstanding = outstanding | (vec & ~mask_model);    // Pending hits merge
        @(negedge clk_i);
        hit_i = '0;
    endtask

    // Pop one DATA entry and strike it from the expected set
    task automatic take_entry();
        apb_data_t d;
        int        pix;
        reg_read(REG_DATA, d);
        if (!d[DATA_VALID_BIT])
            check_data(32'h0, d);                   // Empty reads as zero
        else
        begin
            check_data(32'h0, d & 32'h7fff_ff00);   // Unused bits clear
            pix = d[7:4] * COLS + d[3:0];
            if (d[7:4] >= ROWS || d[3:0] >= COLS || !outstanding[pix])
                abort_run($sformatf("%s: pixel at row %0d col %0d read out but not expected",
                                    test_name, d[7:4], d[3:0]));
            else
                outstanding[pix] = 1'b0;
        end
    endtask

    task automatic wait_for_count(input fifo_cnt_t cnt);
        apb_data_t d;
        int        polls;
        polls = 0;
        reg_read(REG_STATUS, d);
        while (fifo_cnt_t'(d[5:0]) != cnt)
        begin
            if (polls >= POLL_LIMIT)
                abort_run($sformatf("%s: FIFO level stuck at %0d while waiting for %0d",
                                    test_name, d[5:0], cnt));
            else
            begin
                polls++;
                reg_read(REG_STATUS, d);
            end
        end
    endtask

    // Read until every expected pixel came out, then look for strays
    task automatic drain_and_compare();
        apb_data_t d;
        int        reads;
        reads = 0;
        while (outstanding != '0)
        begin
            if (reads >= DRAIN_LIMIT)
                abort_run($sformatf("%s: pixels %h were never read out", test_name, outstanding));
            else
            begin
                take_entry();
                reads++;
            end
        end
        idle_cycles(8);                             // Room for a duplicate to show up
        reg_read(REG_STATUS, d);
        check_data(status_word(0), d);
        reg_read(REG_DATA, d);
        check_data(32'h0, d);
        check_flag("irq_o", 1'b0, irq_o);
    endtask

    initial
    begin
        apb_data_t      d;
        logic           err;
        logic [PIX-1:0] hv;
        int             left;
        int             pix;
        void'($urandom(32'h5c0d));                  // Seeded once
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        hit_i       = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        outstanding = '0;
        mask_model  = '0;
        enabled     = 1'b0;
        test_name   = "reset";
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;

        test_name = "registers";
        reg_read(REG_CTRL, d);
        check_data(32'h0, d);                       // Disabled after reset
        reg_read(REG_MASK, d);
        check_data(32'h0, d);
        reg_write(REG_MASK, 32'hdead_beef);
        reg_read(REG_MASK, d);
        check_data(32'hdead_beef, d);
        reg_write(REG_MASK, 32'h0);
        reg_write(REG_CTRL, 32'h1);
        enabled = 1'b1;
        reg_read(REG_CTRL, d);
        check_data(32'h1, d);
        apb_xfer(1'b1, 4'h6, 32'hffff_ffff, d, err);    // Unmapped write
        check_flag("pslverr_o", 1'b1, err);
        apb_xfer(1'b0, 4'h2, 32'h0, d, err);            // Unmapped read
        check_flag("pslverr_o", 1'b1, err);
        check_data(32'h0, d);
        reg_read(REG_MASK, d);
        check_data(32'h0, d);                       // Unmapped write ignored
        reg_read(REG_DATA, d);
        check_data(32'h0, d);
        reg_read(REG_STATUS, d);
        check_data(status_word(0), d);

        // All pixels at once, pointers still at zero
        test_name = "row_major";
        pulse_hits('1);
        wait_for_count(fifo_cnt_t'(FIFO_DEPTH));
        for (int i = 0; i < PIX; i++)
        begin
            reg_read(REG_DATA, d);
            check_flag("DATA valid bit", 1'b1, d[DATA_VALID_BIT]);
            check_addr(row_addr_t'(i / COLS), col_addr_t'(i % COLS), d[7:4], d[3:0]);
            outstanding[i] = 1'b0;
            left = PIX - 1 - i;                     // Pixels not yet read
            idle_cycles(2);
            check_flag("irq_o", enabled && (left != 0), irq_o);
            reg_read(REG_STATUS, d);
            left = (left > FIFO_DEPTH) ? FIFO_DEPTH : left;    // Refilled up to depth
            check_count(fifo_cnt_t'(left), fifo_cnt_t'(d[5:0]));
            check_data(status_word(fifo_cnt_t'(left)), d);
        end
        reg_read(REG_DATA, d);
        check_data(32'h0, d);

        test_name = "random";
        for (int i = 0; i < RANDOM_STEPS; i++)
        begin
            if (i % 100 == 0)
            begin
                mask_model = PIX'($urandom) & PIX'($urandom);   // Roughly a quarter masked
                reg_write(REG_MASK, apb_data_t'(mask_model));
            end
            hv = PIX'($urandom) & PIX'($urandom) & ~outstanding;
            pulse_hits(hv);
            if ($urandom_range(2) == 0)
                take_entry();
        end
        drain_and_compare();

        test_name  = "masking";
        mask_model = PIX'($urandom) | PIX'(1);
        reg_write(REG_MASK, apb_data_t'(mask_model));
        pulse_hits('1);
        reg_write(REG_CTRL, 32'h0);
        enabled = 1'b0;
        pulse_hits('1);                             // Ignored while disabled
        idle_cycles(2);
        check_flag("irq_o", 1'b0, irq_o);
        drain_and_compare();                        // Pending pixels still drain
        pulse_hits('1);
        drain_and_compare();
        reg_write(REG_CTRL, 32'h1);
        enabled = 1'b1;
        reg_write(REG_MASK, 32'h0);
        mask_model = '0;

        // FIFO full, later hits stay pending and merge
        test_name = "backpressure";
        pulse_hits(FIRST_BATCH);
        wait_for_count(fifo_cnt_t'(FIFO_DEPTH));
        pulse_hits(~FIRST_BATCH);
        for (int i = 0; i < 6; i++)
            pulse_hits(PIX'($urandom) & ~FIRST_BATCH);
        idle_cycles(4);
        reg_read(REG_STATUS, d);
        check_count(fifo_cnt_t'(FIFO_DEPTH), fifo_cnt_t'(d[5:0]));
        check_data(status_word(fifo_cnt_t'(FIFO_DEPTH)), d);
        check_flag("irq_o", 1'b1, irq_o);

        // Stalled pixels hit again on the edge that frees one slot
        take_entry();
        hit_i = ~FIRST_BATCH;                       // Meets the clear of the offered pixel
        @(negedge clk_i);
        hit_i = '0;
        for (int i = 0; i < FIFO_DEPTH - 1; i++)
            take_entry();                           // Rest of the first batch
        reg_read(REG_DATA, d);                      // Pixel moved on the hit edge
        check_flag("DATA valid bit", 1'b1, d[DATA_VALID_BIT]);
        pix = d[7:4] * COLS + d[3:0];
        if (d[7:4] >= ROWS || d[3:0] >= COLS || FIRST_BATCH[pix] || !outstanding[pix])
            abort_run($sformatf("%s: pixel at row %0d col %0d read out but not expected",
                                test_name, d[7:4], d[3:0]));
        drain_and_compare();                        // Same pixel comes out once more

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: all.f
+incdir+dv
design/pix_cfg_pkg.sv
design/pix_apb_pkg.sv
design/pix_addr_if.sv
design/hit_capture.sv
design/rr_arbiter.sv
design/matrix_arbiter.sv
design/addr_fifo.sv
design/apb_readout_regs.sv
design/pix_readout_top.sv
dv/pix_readout_tb.sv
